// ==== Bender.yml ====
package:
  name: pito_soc

sources:
  - include_dirs:
      - design
    files:
      - design/pito_pkg.sv
      - design/pito_dp_ram.sv
      - design/pito_core.sv
      - design/pito_uart_tx.sv
      - design/pito_soc.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/pito_soc_tb.sv

// ==== design/pito_core.sv ====
`timescale 1ns/1ps

module pito_core import pito_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       fetch_en_i,
    output logic       imem_req_o,
    output pito_addr_t imem_addr_o,
    input  pito_data_t imem_rdata_i,
    output logic       dmem_req_o,
    output logic       dmem_we_o,
    output pito_addr_t dmem_addr_o,
    output pito_data_t dmem_wdata_o,
    output logic [3:0] dmem_be_o,
    input  pito_data_t dmem_rdata_i
);

    pito_state_e  state_q, state_d;
    pito_addr_t   pc_q, pc_d;
    pito_addr_t   pc_plus4;
    pito_data_t   regs [32];
    pito_data_t   instr;
    pito_opcode_e opcode;
    logic [4:0]   rs1, rs2, rd;
    logic [2:0]   funct3;
    pito_data_t   rs1_val, rs2_val;
    pito_data_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    pito_data_t   add_b, add_res;
    logic         ne;
    logic         rf_we;
    pito_data_t   rf_wdata;

    //======================================================================
    // Decode
    //======================================================================

    // Instruction word stays valid through EXEC and MEM
    assign instr  = imem_rdata_i;
    assign opcode = pito_opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Adder and comparator
    always_comb begin
        case (opcode)
            OP_OP:    add_b = rs2_val;
            OP_STORE: add_b = imm_s;
            default:  add_b = imm_i;
        endcase
    end

    assign add_res  = rs1_val + add_b;
    assign ne       = (rs1_val != rs2_val);
    assign pc_plus4 = pc_q + 32'd4;

    //======================================================================
    // Sequencer
    //======================================================================

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        imem_req_o = 1'b0;
        dmem_req_o = 1'b0;
        dmem_we_o  = 1'b0;
        rf_we      = 1'b0;
        rf_wdata   = add_res;
        case (state_q)
            ST_IDLE: begin
                if (fetch_en_i) begin
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH: begin
                imem_req_o = 1'b1;
                state_d    = ST_EXEC;
            end
            ST_EXEC: begin
                pc_d    = pc_plus4;
                state_d = ST_FETCH;
                case (opcode)
                    OP_LUI: begin
                        rf_we    = 1'b1;
                        rf_wdata = imm_u;
                    end
                    OP_OPIMM, OP_OP: rf_we = 1'b1;
                    OP_LOAD: begin
                        dmem_req_o = 1'b1;
                        state_d    = ST_MEM;
                    end
                    OP_STORE: begin
                        dmem_req_o = 1'b1;
                        dmem_we_o  = 1'b1;
                        state_d    = ST_MEM;
                    end
                    // Only BNE among the branches
                    OP_BRANCH: begin
                        if (funct3 == 3'b001 && ne) begin
                            pc_d = pc_q + imm_b;
                        end
                    end
                    OP_JAL: begin
                        rf_we    = 1'b1;
                        rf_wdata = pc_plus4;
                        pc_d     = pc_q + imm_j;
                    end
                    default: ;
                endcase
            end
            ST_MEM: begin
                state_d = ST_FETCH;
                if (opcode == OP_LOAD) begin
                    rf_we    = 1'b1;
                    rf_wdata = dmem_rdata_i;
                end
            end
            default: state_d = ST_IDLE;
        endcase
        // Dropping fetch enable parks the core
        if (!fetch_en_i) begin
            state_d = ST_IDLE;
            pc_d    = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we && rd != 5'd0) begin
            regs[rd] <= rf_wdata;
        end
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = add_res;
    assign dmem_wdata_o = rs2_val;
    assign dmem_be_o    = 4'b1111;

    // Branch and jump targets must keep fetches on word boundaries
    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        imem_req_o |-> (imem_addr_o[1:0] == 2'b00)
    ) else $error("pito_core fetch from unaligned address 0x%08h", imem_addr_o);

endmodule

// ==== design/pito_dp_ram.sv ====
`timescale 1ns/1ps

module pito_dp_ram import pito_pkg::*; #(
    parameter int unsigned NumWords  = 256,
    parameter int unsigned AddrWidth = 8
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 req_i   [2],
    input  logic                 we_i    [2],
    input  logic [AddrWidth-1:0] addr_i  [2],
    input  pito_data_t           wdata_i [2],
    input  logic [3:0]           be_i    [2],
    output pito_data_t           rdata_o [2]
);

    pito_data_t mem [NumWords];

    // Byte-enabled writes
    // Port 1 goes first so port 0 wins on a shared word
    always_ff @(posedge clk) begin
        for (int p = 1; p >= 0; p--) begin
            if (req_i[p] && we_i[p]) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[p][b]) begin
                        mem[addr_i[p]][b*8 +: 8] <= wdata_i[p][b*8 +: 8];
                    end
                end
            end
        end
    end

    // Registered reads, data held until the next read request
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (req_i[p] && !we_i[p]) begin
                rdata_o[p] <= mem[addr_i[p]];
            end
        end
    end

    // Every request must land inside the array
    for (genvar p = 0; p < 2; p++) begin : g_addr_chk
        a_addr_in_range: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            req_i[p] |-> (addr_i[p] < NumWords)
        ) else $error("pito_dp_ram port %0d address %0d out of range", p, addr_i[p]);
    end

endmodule

// ==== design/pito_params.svh ====
`ifndef PITO_PARAMS_SVH
`define PITO_PARAMS_SVH

//======================================================================
// Memory geometry
//======================================================================

// Depths in 32-bit words
`define PITO_IMEM_WORDS 256
`define PITO_DMEM_WORDS 256

// Word address widths
`define PITO_IMEM_AW 8
`define PITO_DMEM_AW 8

//======================================================================
// Memory-mapped I/O
//======================================================================

`define PITO_UART_TX_ADDR   32'h8000_0000
`define PITO_UART_STAT_ADDR 32'h8000_0001

// Clock cycles per serial bit
`define PITO_UART_CLKS_PER_BIT 8

`endif

// ==== design/pito_pkg.sv ====
package pito_pkg;

    // Basic machine types
    typedef logic [31:0] pito_data_t;
    typedef logic [31:0] pito_addr_t;

    //======================================================================
    // Major opcodes handled by the core
    //======================================================================

    // Anything outside this list runs as a no-op
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } pito_opcode_e;

    //======================================================================
    // Core sequencing
    //======================================================================

    // IDLE holds the PC at zero until fetch is enabled
    // FETCH issues the instruction read
    // EXEC decodes, writes back and issues data requests
    // MEM collects load data
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_EXEC  = 2'd2,
        ST_MEM   = 2'd3
    } pito_state_e;

endpackage

// ==== design/pito_soc.sv ====
`timescale 1ns/1ps

`include "pito_params.svh"

module pito_soc import pito_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     fetch_en_i,
    input  logic                     ext_imem_req_i,
    input  logic                     ext_imem_we_i,
    input  logic [`PITO_IMEM_AW-1:0] ext_imem_addr_i,
    input  pito_data_t               ext_imem_wdata_i,
    input  logic [3:0]               ext_imem_be_i,
    output pito_data_t               ext_imem_rdata_o,
    input  logic                     ext_dmem_req_i,
    input  logic                     ext_dmem_we_i,
    input  logic [`PITO_DMEM_AW-1:0] ext_dmem_addr_i,
    input  pito_data_t               ext_dmem_wdata_i,
    input  logic [3:0]               ext_dmem_be_i,
    output pito_data_t               ext_dmem_rdata_o,
    output logic                     uart_tx_o
);

    // Core side
    logic       core_imem_req;
    pito_addr_t core_imem_addr;
    logic       core_dmem_req;
    logic       core_dmem_we;
    pito_addr_t core_dmem_addr;
    pito_data_t core_dmem_wdata;
    logic [3:0] core_dmem_be;
    pito_data_t core_dmem_rdata;

    // Memory ports, 0 external and 1 local
    logic                     imem_req   [2];
    logic                     imem_we    [2];
    logic [`PITO_IMEM_AW-1:0] imem_addr  [2];
    pito_data_t               imem_wdata [2];
    logic [3:0]               imem_be    [2];
    pito_data_t               imem_rdata [2];
    logic                     dmem_req   [2];
    logic                     dmem_we    [2];
    logic [`PITO_DMEM_AW-1:0] dmem_addr  [2];
    pito_data_t               dmem_wdata [2];
    logic [3:0]               dmem_be    [2];
    pito_data_t               dmem_rdata [2];

    logic       dmem_out_bound;
    logic       uart_wr;
    logic       uart_busy;
    logic       stat_rd;
    logic       stat_rd_q;
    pito_data_t stat_word_q;

    //======================================================================
    // Core
    //======================================================================

    pito_core i_core (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fetch_en_i  (fetch_en_i),
        .imem_req_o  (core_imem_req),
        .imem_addr_o (core_imem_addr),
        .imem_rdata_i(imem_rdata[1]),
        .dmem_req_o  (core_dmem_req),
        .dmem_we_o   (core_dmem_we),
        .dmem_addr_o (core_dmem_addr),
        .dmem_wdata_o(core_dmem_wdata),
        .dmem_be_o   (core_dmem_be),
        .dmem_rdata_i(core_dmem_rdata)
    );

    //======================================================================
    // Memories
    //======================================================================

    assign imem_req[0]      = ext_imem_req_i;
    assign imem_we[0]       = ext_imem_we_i;
    assign imem_addr[0]     = ext_imem_addr_i;
    assign imem_wdata[0]    = ext_imem_wdata_i;
    assign imem_be[0]       = ext_imem_be_i;
    assign ext_imem_rdata_o = imem_rdata[0];

    // Core only reads instructions
    assign imem_req[1]   = core_imem_req;
    assign imem_we[1]    = 1'b0;
    assign imem_addr[1]  = core_imem_addr[`PITO_IMEM_AW+1:2];
    assign imem_wdata[1] = '0;
    assign imem_be[1]    = '0;

    pito_dp_ram #(
        .NumWords (`PITO_IMEM_WORDS),
        .AddrWidth(`PITO_IMEM_AW)
    ) i_imem (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .req_i  (imem_req),
        .we_i   (imem_we),
        .addr_i (imem_addr),
        .wdata_i(imem_wdata),
        .be_i   (imem_be),
        .rdata_o(imem_rdata)
    );

    assign dmem_req[0]      = ext_dmem_req_i;
    assign dmem_we[0]       = ext_dmem_we_i;
    assign dmem_addr[0]     = ext_dmem_addr_i;
    assign dmem_wdata[0]    = ext_dmem_wdata_i;
    assign dmem_be[0]       = ext_dmem_be_i;
    assign ext_dmem_rdata_o = dmem_rdata[0];

    // Stores above the data region never reach the RAM
    assign dmem_out_bound = |core_dmem_addr[31:22];
    assign dmem_req[1]    = core_dmem_req;
    assign dmem_we[1]     = core_dmem_we && !dmem_out_bound;
    assign dmem_addr[1]   = core_dmem_addr[`PITO_DMEM_AW+1:2];
    assign dmem_wdata[1]  = core_dmem_wdata;
    assign dmem_be[1]     = core_dmem_be;

    pito_dp_ram #(
        .NumWords (`PITO_DMEM_WORDS),
        .AddrWidth(`PITO_DMEM_AW)
    ) i_dmem (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .req_i  (dmem_req),
        .we_i   (dmem_we),
        .addr_i (dmem_addr),
        .wdata_i(dmem_wdata),
        .be_i   (dmem_be),
        .rdata_o(dmem_rdata)
    );

    //======================================================================
    // UART and status read-back
    //======================================================================

    assign uart_wr = core_dmem_req && core_dmem_we && (core_dmem_addr == `PITO_UART_TX_ADDR);
    assign stat_rd = core_dmem_req && !core_dmem_we && (core_dmem_addr == `PITO_UART_STAT_ADDR);

    pito_uart_tx i_uart_tx (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .wr_i   (uart_wr),
        .data_i (core_dmem_wdata[7:0]),
        .busy_o (uart_busy),
        .tx_o   (uart_tx_o)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stat_rd_q <= 1'b0;
        end else begin
            stat_rd_q <= stat_rd;
        end
    end

    // Busy in bit 8, no receive data below it
    always_ff @(posedge clk) begin
        if (stat_rd) begin
            stat_word_q <= {23'b0, uart_busy, 8'b0};
        end
    end

    assign core_dmem_rdata = stat_rd_q ? stat_word_q : dmem_rdata[1];

endmodule

// ==== design/pito_uart_tx.sv ====
`timescale 1ns/1ps

`include "pito_params.svh"

module pito_uart_tx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       wr_i,
    input  logic [7:0] data_i,
    output logic       busy_o,
    output logic       tx_o
);

    localparam int unsigned ClksPerBit = `PITO_UART_CLKS_PER_BIT;
    localparam int unsigned CntW       = $clog2(ClksPerBit);

    logic [CntW-1:0] baud_cnt_q;
    logic [3:0]      bit_cnt_q;
    logic [8:0]      shift_q;
    logic            busy_q;
    logic            tx_q;

    // Start bit goes out together with busy
    // Shift register holds data then stop bit, LSB first
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            shift_q    <= '1;
            busy_q     <= 1'b0;
            tx_q       <= 1'b1;
        end else if (!busy_q) begin
            if (wr_i) begin
                shift_q    <= {1'b1, data_i};
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
                busy_q     <= 1'b1;
                tx_q       <= 1'b0;
            end
        end else if (baud_cnt_q == CntW'(ClksPerBit - 1)) begin
            baud_cnt_q <= '0;
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;
                tx_q   <= 1'b1;
            end else begin
                tx_q      <= shift_q[0];
                shift_q   <= {1'b1, shift_q[8:1]};
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    assign busy_o = busy_q;
    assign tx_o   = tx_q;

    // Line idles high between frames
    a_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !busy_o |-> tx_o
    ) else $error("pito_uart_tx line low while idle");

endmodule

// ==== sources.f ====
+incdir+design
design/pito_pkg.sv
design/pito_dp_ram.sv
design/pito_core.sv
design/pito_uart_tx.sv
design/pito_soc.sv
tests/pito_soc_tb.sv

// ==== tests/pito_soc_tb.sv ====
`timescale 1ns/1ps

`include "pito_params.svh"

module pito_soc_tb import pito_pkg::*; ();

    localparam int unsigned ClkPeriod   = 20;
    localparam int unsigned ResetCycles = 10;
    localparam int unsigned BitClks     = `PITO_UART_CLKS_PER_BIT;
    localparam int unsigned RunLimit    = 3000;
    localparam int unsigned NumRuns     = 5;
    localparam int unsigned FrameLimit  = 12 * BitClks;
    localparam int unsigned NumFrames   = 6;
    localparam int unsigned WatchdogCycles =
        ResetCycles + NumRuns * (RunLimit + 200) + 2 * NumFrames * FrameLimit + 2000;

    // Completion flag written by every program before it parks
    localparam logic [`PITO_DMEM_AW-1:0] DoneWord = 8'hff;
    localparam logic [11:0]              DoneAddr = 12'h3fc;
    localparam pito_data_t               DoneMark = 32'h0000_06d5;

    logic                     clk;
    logic                     rst_n;
    logic                     fetch_en;
    logic                     ext_imem_req;
    logic                     ext_imem_we;
    logic [`PITO_IMEM_AW-1:0] ext_imem_addr;
    pito_data_t               ext_imem_wdata;
    logic [3:0]               ext_imem_be;
    pito_data_t               ext_imem_rdata;
    logic                     ext_dmem_req;
    logic                     ext_dmem_we;
    logic [`PITO_DMEM_AW-1:0] ext_dmem_addr;
    pito_data_t               ext_dmem_wdata;
    logic [3:0]               ext_dmem_be;
    pito_data_t               ext_dmem_rdata;
    logic                     uart_tx;

    int unsigned errors;
    int unsigned checks;
    logic [31:0] lfsr_q;
    pito_data_t  prog [$];
    logic [7:0]  rx_bytes [$];

    pito_soc i_pito_soc (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .fetch_en_i      (fetch_en),
        .ext_imem_req_i  (ext_imem_req),
        .ext_imem_we_i   (ext_imem_we),
        .ext_imem_addr_i (ext_imem_addr),
        .ext_imem_wdata_i(ext_imem_wdata),
        .ext_imem_be_i   (ext_imem_be),
        .ext_imem_rdata_o(ext_imem_rdata),
        .ext_dmem_req_i  (ext_dmem_req),
        .ext_dmem_we_i   (ext_dmem_we),
        .ext_dmem_addr_i (ext_dmem_addr),
        .ext_dmem_wdata_i(ext_dmem_wdata),
        .ext_dmem_be_i   (ext_dmem_be),
        .ext_dmem_rdata_o(ext_dmem_rdata),
        .uart_tx_o       (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    //======================================================================
    // Random bits and instruction encoding
    //======================================================================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic pito_data_t lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic pito_data_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_OPIMM};
    endfunction

    function automatic pito_data_t add(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, OP_OP};
    endfunction

    function automatic pito_data_t lw(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OP_LOAD};
    endfunction

    function automatic pito_data_t sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic pito_data_t bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic pito_data_t jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // LUI takes the rounded upper part since ADDI sign-extends
    task automatic load_const(input logic [4:0] rd, input pito_data_t value);
        pito_data_t hi;
        hi = value + 32'h800;
        prog.push_back(lui(rd, hi[31:12]));
        prog.push_back(addi(rd, rd, value[11:0]));
    endtask

    task automatic end_program();
        prog.push_back(addi(31, 0, DoneMark[11:0]));
        prog.push_back(sw(31, 0, DoneAddr));
        prog.push_back(jal(0, 21'd0));
    endtask

    //======================================================================
    // External port access and program control
    //======================================================================

    task automatic write_imem(input logic [`PITO_IMEM_AW-1:0] addr, input pito_data_t data);
        @(negedge clk);
        ext_imem_req   = 1'b1;
        ext_imem_we    = 1'b1;
        ext_imem_addr  = addr;
        ext_imem_wdata = data;
        ext_imem_be    = 4'hf;
        @(negedge clk);
        ext_imem_req = 1'b0;
        ext_imem_we  = 1'b0;
    endtask

    task automatic read_imem(input logic [`PITO_IMEM_AW-1:0] addr, output pito_data_t data);
        @(negedge clk);
        ext_imem_req  = 1'b1;
        ext_imem_we   = 1'b0;
        ext_imem_addr = addr;
        @(negedge clk);
        ext_imem_req = 1'b0;
        data         = ext_imem_rdata;
    endtask

    task automatic write_dmem(input logic [`PITO_DMEM_AW-1:0] addr, input pito_data_t data,
                              input logic [3:0] be);
        @(negedge clk);
        ext_dmem_req   = 1'b1;
        ext_dmem_we    = 1'b1;
        ext_dmem_addr  = addr;
        ext_dmem_wdata = data;
        ext_dmem_be    = be;
        @(negedge clk);
        ext_dmem_req = 1'b0;
        ext_dmem_we  = 1'b0;
    endtask

    // Read data is registered at the rising edge in between
    task automatic read_dmem(input logic [`PITO_DMEM_AW-1:0] addr, output pito_data_t data);
        @(negedge clk);
        ext_dmem_req  = 1'b1;
        ext_dmem_we   = 1'b0;
        ext_dmem_addr = addr;
        @(negedge clk);
        ext_dmem_req = 1'b0;
        data         = ext_dmem_rdata;
    endtask

    task automatic compare_word(input string name, input pito_data_t got, input pito_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_program(input string name);
        pito_data_t  flag;
        pito_data_t  img_word;
        int unsigned waited;
        write_dmem(DoneWord, 32'h0, 4'hf);
        for (int i = 0; i < prog.size(); i++) begin
            write_imem(8'(i), prog[i]);
        end
        // Program image reads back intact before the core starts
        for (int i = 0; i < prog.size(); i++) begin
            read_imem(8'(i), img_word);
            compare_word($sformatf("ext_imem_rdata_o[word 0x%02h]", i), img_word, prog[i]);
        end
        @(negedge clk);
        fetch_en = 1'b1;
        waited   = 0;
        flag     = '0;
        // Poll the completion flag over the external port
        while (flag !== DoneMark && waited < RunLimit) begin
            read_dmem(DoneWord, flag);
            waited += 2;
        end
        @(negedge clk);
        fetch_en = 1'b0;
        checks++;
        if (flag !== DoneMark) begin
            $display("Program %s did not finish within %0d cycles", name, RunLimit);
            errors++;
        end
        prog.delete();
    endtask

    task automatic wait_uart_bytes(input int unsigned count);
        int unsigned waited;
        waited = 0;
        while (rx_bytes.size() < count && waited < count * FrameLimit) begin
            @(negedge clk);
            waited++;
        end
        // One more frame time so a stray extra byte would show up
        repeat (FrameLimit) @(negedge clk);
        checks++;
        if (rx_bytes.size() != count) begin
            $display("UART monitor got %0d bytes where %0d were expected",
                     rx_bytes.size(), count);
            errors++;
        end
    endtask

    // Samples each bit near its middle, on falling clock edges
    initial begin : uart_monitor
        logic [7:0] rx;
        forever begin
            @(negedge uart_tx);
            repeat (BitClks / 2) @(negedge clk);
            checks++;
            if (uart_tx !== 1'b0) begin
                $display("UART start bit did not stay low until mid-bit");
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (BitClks) @(negedge clk);
                rx[i] = uart_tx;
            end
            repeat (BitClks) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                $display("UART stop bit missing after byte 0x%02h", rx);
                errors++;
            end
            rx_bytes.push_back(rx);
        end
    end

    //======================================================================
    // Directed tests
    //======================================================================

    task automatic ext_dmem_access();
        pito_data_t wr [8];
        pito_data_t rd;
        pito_data_t upd;
        pito_data_t merged;
        logic [3:0] be;
        for (int i = 0; i < 8; i++) begin
            wr[i] = random_bits(32);
            write_dmem(8'h10 + 8'(i), wr[i], 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            read_dmem(8'h10 + 8'(i), rd);
            compare_word($sformatf("ext_dmem_rdata_o[word 0x%02h]", 8'h10 + i), rd, wr[i]);
        end
        // Partial write keeps the bytes that are not enabled
        upd = random_bits(32);
        be  = 4'b0110;
        write_dmem(8'h13, upd, be);
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = be[b] ? upd[b*8 +: 8] : wr[3][b*8 +: 8];
        end
        read_dmem(8'h13, rd);
        compare_word("ext_dmem_rdata_o[word 0x13 partial]", rd, merged);
    endtask

    task automatic arith_store();
        pito_data_t a;
        pito_data_t b;
        pito_data_t c;
        pito_data_t got;
        a = random_bits(32);
        b = random_bits(32);
        c = random_bits(12);
        load_const(1, a);
        load_const(2, b);
        prog.push_back(add(3, 1, 2));
        prog.push_back(addi(3, 3, c[11:0]));
        prog.push_back(sw(3, 0, 12'h100));
        end_program();
        run_program("arith_store");
        read_dmem(8'h40, got);
        compare_word("ext_dmem_rdata_o[sum]", got, a + b + {{20{c[11]}}, c[11:0]});
    endtask

    task automatic load_loop();
        pito_data_t  v;
        pito_data_t  exp;
        pito_data_t  got;
        int unsigned n;
        v = random_bits(32);
        n = random_bits(3) + 1;
        write_dmem(8'h60, v, 4'hf);
        prog.push_back(lw(1, 0, 12'h180));
        prog.push_back(addi(2, 0, 12'(n)));
        // Doubling loop, count in x2
        prog.push_back(add(1, 1, 1));
        prog.push_back(addi(2, 2, 12'hfff));
        prog.push_back(bne(2, 0, -13'sd8));
        prog.push_back(sw(1, 0, 12'h184));
        end_program();
        run_program("load_loop");
        exp = v;
        repeat (n) exp = exp + exp;
        read_dmem(8'h61, got);
        compare_word("ext_dmem_rdata_o[loop result]", got, exp);
    endtask

    task automatic uart_transmit();
        string msg;
        msg = "Pito!";
        rx_bytes.delete();
        prog.push_back(lui(6, 20'h80000));
        for (int i = 0; i < msg.len(); i++) begin
            prog.push_back(lw(5, 6, 12'h001));
            prog.push_back(bne(5, 0, -13'sd4));
            prog.push_back(addi(7, 0, {4'h0, msg[i]}));
            prog.push_back(sw(7, 6, 12'h000));
        end
        end_program();
        run_program("uart_transmit");
        wait_uart_bytes(msg.len());
        for (int i = 0; i < msg.len() && i < rx_bytes.size(); i++) begin
            compare_word($sformatf("uart_tx_o[byte %0d]", i), rx_bytes[i], msg[i]);
        end
    endtask

    task automatic out_of_bound_store();
        pito_data_t pat;
        pito_data_t got;
        pat = random_bits(32);
        write_dmem(8'h00, pat, 4'hf);
        write_dmem(8'h01, ~pat, 4'hf);
        prog.push_back(lui(1, 20'h01000));
        prog.push_back(addi(2, 0, 12'h123));
        prog.push_back(sw(2, 1, 12'h000));
        prog.push_back(addi(3, 0, 12'h5a5));
        prog.push_back(sw(3, 0, 12'h004));
        end_program();
        run_program("out_of_bound_store");
        read_dmem(8'h00, got);
        compare_word("ext_dmem_rdata_o[word 0x00]", got, pat);
        read_dmem(8'h01, got);
        compare_word("ext_dmem_rdata_o[marker]", got, 32'h0000_05a5);
    endtask

    task automatic status_while_busy();
        pito_data_t got;
        rx_bytes.delete();
        write_dmem(8'h70, 32'hffff_ffff, 4'hf);
        prog.push_back(lui(6, 20'h80000));
        prog.push_back(lw(5, 6, 12'h001));
        prog.push_back(bne(5, 0, -13'sd4));
        prog.push_back(addi(7, 0, 12'h0c3));
        prog.push_back(sw(7, 6, 12'h000));
        prog.push_back(lw(8, 6, 12'h001));
        prog.push_back(sw(8, 0, 12'h1c0));
        end_program();
        run_program("status_while_busy");
        read_dmem(8'h70, got);
        compare_word("ext_dmem_rdata_o[status]", got, 32'h0000_0100);
        wait_uart_bytes(1);
        if (rx_bytes.size() > 0) begin
            compare_word("uart_tx_o[byte 0]", rx_bytes[0], 32'h0000_00c3);
        end
    endtask

    //======================================================================
    // Sequence and watchdog
    //======================================================================

    initial begin
        rst_n          = 1'b0;
        fetch_en       = 1'b0;
        ext_imem_req   = 1'b0;
        ext_imem_we    = 1'b0;
        ext_imem_addr  = '0;
        ext_imem_wdata = '0;
        ext_imem_be    = '0;
        ext_dmem_req   = 1'b0;
        ext_dmem_we    = 1'b0;
        ext_dmem_addr  = '0;
        ext_dmem_wdata = '0;
        ext_dmem_be    = '0;
        lfsr_q         = 32'h53eb;
        errors         = 0;
        checks         = 0;
        repeat (ResetCycles) @(negedge clk);
        rst_n = 1'b1;
        ext_dmem_access();
        arith_store();
        load_loop();
        uart_transmit();
        out_of_bound_store();
        status_while_busy();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, run aborted", WatchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
